/* common/decode_pkg.sv */
// ------------------------------
// Shared types for the decode stage
// Widths, op codes and the bundles that cross stage boundaries
// ------------------------------

package decode_pkg;

   localparam int XLEN      = 32;
   localparam int RF_AWIDTH = 5;
   localparam int RF_DEPTH  = 32;

   typedef logic [XLEN-1:0]      xlen_t;
   typedef logic [RF_AWIDTH-1:0] rf_addr_t;
   typedef logic [3:0]           exc_code_t;

   localparam exc_code_t EXC_CODE_ILLEGAL_INSTR = 4'd2;
   localparam exc_code_t EXC_CODE_NO_EXCEPTION  = 4'd15;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      OPCODE_LOAD   = 5'b00000,
      OPCODE_IMM    = 5'b00100,
      OPCODE_AUIPC  = 5'b00101,
      OPCODE_STORE  = 5'b01000,
      OPCODE_ARITH  = 5'b01100,
      OPCODE_LUI    = 5'b01101,
      OPCODE_BRANCH = 5'b11000,
      OPCODE_JALR   = 5'b11001,
      OPCODE_JAL    = 5'b11011
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_OPS_NONE = 4'd0,
      ALU_OPS_ADD,
      ALU_OPS_SUB,
      ALU_OPS_SLL,
      ALU_OPS_SLT,
      ALU_OPS_SLTU,
      ALU_OPS_XOR,
      ALU_OPS_SRL,
      ALU_OPS_SRA,
      ALU_OPS_OR,
      ALU_OPS_AND,
      ALU_OPS_COPY_OPR2                                  // LUI passes the immediate
   } alu_ops_e;

   typedef enum logic [2:0] {
      LD_OPS_NONE = 3'd0,
      LD_OPS_LB,
      LD_OPS_LH,
      LD_OPS_LW,
      LD_OPS_LBU,
      LD_OPS_LHU
   } ld_ops_e;

   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'd0,
      ST_OPS_SB,
      ST_OPS_SH,
      ST_OPS_SW
   } st_ops_e;

   typedef enum logic [2:0] {
      BR_OPS_NONE = 3'd0,
      BR_OPS_EQ,
      BR_OPS_NE,
      BR_OPS_LT,
      BR_OPS_GE,
      BR_OPS_LTU,
      BR_OPS_GEU
   } br_ops_e;

   typedef enum logic [1:0] {
      RD_WRB_NONE = 2'd0,
      RD_WRB_ALU,
      RD_WRB_DMEM,
      RD_WRB_INC_PC                                      // Link address for jumps
   } rd_wrb_sel_e;

   typedef enum logic {ALU_OPR1_PC, ALU_OPR1_REG} alu_opr1_sel_e;
   typedef enum logic {ALU_OPR2_REG, ALU_OPR2_IMM} alu_opr2_sel_e;

   typedef enum logic [2:0] {
      IMM_SEL_I,
      IMM_SEL_SHAMT,
      IMM_SEL_S,
      IMM_SEL_B,
      IMM_SEL_U,
      IMM_SEL_J
   } imm_sel_e;

   typedef struct packed {
      xlen_t     pc;
      xlen_t     pc_next;
      xlen_t     instr;
      logic      exc_req;                                // Fetch side fault
      exc_code_t exc_code;
      logic      irq_req;
      logic      instr_flushed;
   } if2id_s;

   typedef struct packed {
      logic     rd_wr_req;
      rf_addr_t rd_addr;
      xlen_t    rd_data;
   } wrb2id_s;

   typedef struct packed {
      alu_ops_e      alu_ops;
      ld_ops_e       ld_ops;
      st_ops_e       st_ops;
      br_ops_e       branch_ops;
      rd_wrb_sel_e   rd_wrb_sel;
      alu_opr1_sel_e alu_opr1_sel;
      alu_opr2_sel_e alu_opr2_sel;
      logic          rd_wr_req;
      logic          jump_req;
      logic          branch_req;
      logic          exc_req;
      logic          irq_req;
   } id2exe_ctrl_s;

   typedef struct packed {
      xlen_t     imm;
      xlen_t     rs1_data;
      xlen_t     rs2_data;
      xlen_t     instr;
      xlen_t     pc;
      xlen_t     pc_next;
      exc_code_t exc_code;
      logic      instr_flushed;
   } id2exe_data_s;

   // Values held by the ID/EXE register out of reset
   localparam id2exe_ctrl_s ID2EXE_CTRL_RESET = '{
      alu_ops:      ALU_OPS_NONE,
      ld_ops:       LD_OPS_NONE,
      st_ops:       ST_OPS_NONE,
      branch_ops:   BR_OPS_NONE,
      rd_wrb_sel:   RD_WRB_NONE,
      alu_opr1_sel: ALU_OPR1_PC,
      alu_opr2_sel: ALU_OPR2_REG,
      default:      1'b0
   };

   localparam id2exe_data_s ID2EXE_DATA_RESET = '{
      exc_code: EXC_CODE_NO_EXCEPTION,
      default:  '0
   };

endpackage : decode_pkg

/* decoder/ctrl_decoder.sv */
// ------------------------------
// RV32I control decoder, purely combinational
// Produces the control bundle, immediate format and exception code
// ------------------------------

`timescale 1ns/1ps

module ctrl_decoder (
   input  decode_pkg::xlen_t        instr_i,
   input  logic                     fetch_exc_req_i,
   input  decode_pkg::exc_code_t    fetch_exc_code_i,
   output decode_pkg::id2exe_ctrl_s ctrl_o,
   output decode_pkg::imm_sel_e     imm_sel_o,
   output decode_pkg::exc_code_t    exc_code_o
);

   import decode_pkg::*;

   rv_opcode_e opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       illegal_instr;

   assign opcode = rv_opcode_e'(instr_i[6:2]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   always_comb begin
      ctrl_o        = ID2EXE_CTRL_RESET;                 // Everything idle by default
      imm_sel_o     = IMM_SEL_I;
      exc_code_o    = EXC_CODE_NO_EXCEPTION;
      illegal_instr = (instr_i[1:0] != 2'b11);           // Compressed space is not supported

      case (opcode)
         OPCODE_ARITH: begin
            ctrl_o.rd_wrb_sel   = RD_WRB_ALU;
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel = ALU_OPR2_REG;
            ctrl_o.rd_wr_req    = 1'b1;
            case (funct7)
               7'b0000000: begin
                  case (funct3)
                     3'b000: ctrl_o.alu_ops = ALU_OPS_ADD;
                     3'b001: ctrl_o.alu_ops = ALU_OPS_SLL;
                     3'b010: ctrl_o.alu_ops = ALU_OPS_SLT;
                     3'b011: ctrl_o.alu_ops = ALU_OPS_SLTU;
                     3'b100: ctrl_o.alu_ops = ALU_OPS_XOR;
                     3'b101: ctrl_o.alu_ops = ALU_OPS_SRL;
                     3'b110: ctrl_o.alu_ops = ALU_OPS_OR;
                     default: ctrl_o.alu_ops = ALU_OPS_AND;
                  endcase
               end
               7'b0100000: begin
                  case (funct3)
                     3'b000:  ctrl_o.alu_ops = ALU_OPS_SUB;
                     3'b101:  ctrl_o.alu_ops = ALU_OPS_SRA;
                     default: illegal_instr  = 1'b1;
                  endcase
               end
               default: illegal_instr = 1'b1;            // M and bit-manip encodings land here
            endcase
         end

         OPCODE_IMM: begin
            ctrl_o.rd_wrb_sel   = RD_WRB_ALU;
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.rd_wr_req    = 1'b1;
            case (funct3)
               3'b000: ctrl_o.alu_ops = ALU_OPS_ADD;
               3'b010: ctrl_o.alu_ops = ALU_OPS_SLT;
               3'b011: ctrl_o.alu_ops = ALU_OPS_SLTU;
               3'b100: ctrl_o.alu_ops = ALU_OPS_XOR;
               3'b110: ctrl_o.alu_ops = ALU_OPS_OR;
               3'b111: ctrl_o.alu_ops = ALU_OPS_AND;
               3'b001: begin
                  imm_sel_o = IMM_SEL_SHAMT;
                  if (funct7 == 7'b0000000) begin
                     ctrl_o.alu_ops = ALU_OPS_SLL;
                  end else begin
                     illegal_instr = 1'b1;
                  end
               end
               default: begin                            // Right shifts
                  imm_sel_o = IMM_SEL_SHAMT;
                  case (funct7)
                     7'b0000000: ctrl_o.alu_ops = ALU_OPS_SRL;
                     7'b0100000: ctrl_o.alu_ops = ALU_OPS_SRA;
                     default:    illegal_instr  = 1'b1;
                  endcase
               end
            endcase
         end

         OPCODE_LUI, OPCODE_AUIPC: begin
            ctrl_o.rd_wrb_sel   = RD_WRB_ALU;
            ctrl_o.alu_opr1_sel = ALU_OPR1_PC;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.rd_wr_req    = 1'b1;
            imm_sel_o           = IMM_SEL_U;
            ctrl_o.alu_ops      = (opcode == OPCODE_LUI) ? ALU_OPS_COPY_OPR2 : ALU_OPS_ADD;
         end

         OPCODE_LOAD: begin
            ctrl_o.rd_wrb_sel   = RD_WRB_DMEM;
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.alu_ops      = ALU_OPS_ADD;           // Address generation
            ctrl_o.rd_wr_req    = 1'b1;
            case (funct3)
               3'b000:  ctrl_o.ld_ops = LD_OPS_LB;
               3'b001:  ctrl_o.ld_ops = LD_OPS_LH;
               3'b010:  ctrl_o.ld_ops = LD_OPS_LW;
               3'b100:  ctrl_o.ld_ops = LD_OPS_LBU;
               3'b101:  ctrl_o.ld_ops = LD_OPS_LHU;
               default: illegal_instr = 1'b1;
            endcase
         end

         OPCODE_STORE: begin
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.alu_ops      = ALU_OPS_ADD;
            imm_sel_o           = IMM_SEL_S;
            case (funct3)
               3'b000:  ctrl_o.st_ops = ST_OPS_SB;
               3'b001:  ctrl_o.st_ops = ST_OPS_SH;
               3'b010:  ctrl_o.st_ops = ST_OPS_SW;
               default: illegal_instr = 1'b1;
            endcase
         end

         OPCODE_BRANCH: begin
            ctrl_o.alu_opr1_sel = ALU_OPR1_PC;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.alu_ops      = ALU_OPS_ADD;           // Target address
            ctrl_o.branch_req   = 1'b1;
            imm_sel_o           = IMM_SEL_B;
            case (funct3)
               3'b000:  ctrl_o.branch_ops = BR_OPS_EQ;
               3'b001:  ctrl_o.branch_ops = BR_OPS_NE;
               3'b100:  ctrl_o.branch_ops = BR_OPS_LT;
               3'b101:  ctrl_o.branch_ops = BR_OPS_GE;
               3'b110:  ctrl_o.branch_ops = BR_OPS_LTU;
               3'b111:  ctrl_o.branch_ops = BR_OPS_GEU;
               default: illegal_instr     = 1'b1;
            endcase
         end

         OPCODE_JALR: begin
            ctrl_o.rd_wrb_sel   = RD_WRB_INC_PC;
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.alu_ops      = ALU_OPS_ADD;
            ctrl_o.rd_wr_req    = 1'b1;
            ctrl_o.jump_req     = 1'b1;
            illegal_instr       = illegal_instr | (funct3 != 3'b000);
         end

         OPCODE_JAL: begin
            ctrl_o.rd_wrb_sel   = RD_WRB_INC_PC;
            ctrl_o.alu_opr1_sel = ALU_OPR1_PC;
            ctrl_o.alu_opr2_sel = ALU_OPR2_IMM;
            ctrl_o.alu_ops      = ALU_OPS_ADD;
            ctrl_o.rd_wr_req    = 1'b1;                  // Target already taken in fetch
            imm_sel_o           = IMM_SEL_J;
         end

         default: illegal_instr = 1'b1;
      endcase

      // Squash the operation on any exception, fetch fault first
      if (illegal_instr || fetch_exc_req_i) begin
         ctrl_o.alu_ops    = ALU_OPS_NONE;
         ctrl_o.ld_ops     = LD_OPS_NONE;
         ctrl_o.st_ops     = ST_OPS_NONE;
         ctrl_o.branch_ops = BR_OPS_NONE;
         ctrl_o.rd_wrb_sel = RD_WRB_NONE;
         ctrl_o.rd_wr_req  = 1'b0;
         ctrl_o.jump_req   = 1'b0;
         ctrl_o.branch_req = 1'b0;
         ctrl_o.exc_req    = 1'b1;
         exc_code_o        = fetch_exc_req_i ? fetch_exc_code_i : EXC_CODE_ILLEGAL_INSTR;
      end
   end

endmodule : ctrl_decoder

/* design/decode_stage.sv */
// ------------------------------
// Decode stage top with the ID/EXE register
// Takes one fetched instruction per cycle, one cycle of latency
// ------------------------------

`timescale 1ns/1ps

module decode_stage (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  decode_pkg::if2id_s       if2id_i,
   input  decode_pkg::wrb2id_s      wrb2id_i,
   output decode_pkg::id2exe_ctrl_s id2exe_ctrl_o,
   output decode_pkg::id2exe_data_s id2exe_data_o
);

   import decode_pkg::*;

   id2exe_ctrl_s dec_ctrl;                               // Decoder view, irq not yet merged
   id2exe_ctrl_s ctrl_next;
   id2exe_data_s data_next;
   imm_sel_e     imm_sel;
   exc_code_t    exc_code;
   xlen_t        imm;
   xlen_t        rs1_data;
   xlen_t        rs2_data;
   id2exe_ctrl_s ctrl_q;
   id2exe_data_s data_q;

   ctrl_decoder u_ctrl_decoder (
      .instr_i          (if2id_i.instr),
      .fetch_exc_req_i  (if2id_i.exc_req),
      .fetch_exc_code_i (if2id_i.exc_code),
      .ctrl_o           (dec_ctrl),
      .imm_sel_o        (imm_sel),
      .exc_code_o       (exc_code)
   );

   imm_gen u_imm_gen (
      .instr_i   (if2id_i.instr),
      .imm_sel_i (imm_sel),
      .imm_o     (imm)
   );

   reg_file u_reg_file (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_addr_i (if2id_i.instr[19:15]),
      .rs2_addr_i (if2id_i.instr[24:20]),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wr_req_i   (wrb2id_i.rd_wr_req),
      .wr_addr_i  (wrb2id_i.rd_addr),
      .wr_data_i  (wrb2id_i.rd_data)
   );

   always_comb begin
      ctrl_next         = dec_ctrl;
      ctrl_next.irq_req = if2id_i.irq_req;               // Interrupt rides along unchanged

      data_next.imm           = imm;
      data_next.rs1_data      = rs1_data;
      data_next.rs2_data      = rs2_data;
      data_next.instr         = if2id_i.instr;
      data_next.pc            = if2id_i.pc;
      data_next.pc_next       = if2id_i.pc_next;
      data_next.exc_code      = exc_code;
      data_next.instr_flushed = if2id_i.instr_flushed;
   end

   // ID/EXE pipeline register
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q <= ID2EXE_CTRL_RESET;
         data_q <= ID2EXE_DATA_RESET;
      end else begin
         ctrl_q <= ctrl_next;
         data_q <= data_next;
      end
   end

   assign id2exe_ctrl_o = ctrl_q;
   assign id2exe_data_o = data_q;

endmodule : decode_stage

/* design/imm_gen.sv */
// ------------------------------
// Immediate generator for the RV32I formats
// Combinational, format chosen by the control decoder
// ------------------------------

`timescale 1ns/1ps

module imm_gen (
   input  decode_pkg::xlen_t    instr_i,
   input  decode_pkg::imm_sel_e imm_sel_i,
   output decode_pkg::xlen_t    imm_o
);

   import decode_pkg::*;

   logic sign;

   assign sign = instr_i[31];

   always_comb begin
      case (imm_sel_i)
         IMM_SEL_SHAMT: begin
            imm_o = xlen_t'(instr_i[24:20]);             // Zero extended shift amount
         end
         IMM_SEL_S: begin
            imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
         end
         IMM_SEL_B: begin
            imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
         end
         IMM_SEL_U: begin
            imm_o = {instr_i[31:12], 12'b0};
         end
         IMM_SEL_J: begin
            imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
         end
         default: begin                                  // I format
            imm_o = {{21{sign}}, instr_i[30:20]};
         end
      endcase
   end

endmodule : imm_gen

/* regfile/reg_file.sv */
// ------------------------------
// Integer register file, 2 read ports and 1 write port
// Reads are combinational, x0 is hard-wired to zero
// ------------------------------

`timescale 1ns/1ps

module reg_file (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  decode_pkg::rf_addr_t rs1_addr_i,
   input  decode_pkg::rf_addr_t rs2_addr_i,
   output decode_pkg::xlen_t    rs1_data_o,
   output decode_pkg::xlen_t    rs2_data_o,
   input  logic                 wr_req_i,
   input  decode_pkg::rf_addr_t wr_addr_i,
   input  decode_pkg::xlen_t    wr_data_i
);

   import decode_pkg::*;

   xlen_t regs [RF_DEPTH];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_req_i && (wr_addr_i != '0)) begin
         regs[wr_addr_i] <= wr_data_i;                   // x0 writes dropped
      end
   end

   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : reg_file

/* run.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator
verilator --binary -j 0 --top-module tb_decode_stage -f vlog.f -o sim_decode_stage \
   && ./obj_dir/sim_decode_stage \
   || { echo "Simulation failed"; exit 1; }

/* tb/tb_decode_stage.sv */
// ------------------------------
// Directed testbench for the decode stage
// Drives fetch and writeback bundles, checks the ID/EXE outputs
// ------------------------------

`timescale 1ns/1ps

module tb_decode_stage;

   import decode_pkg::*;

   localparam int MAX_CYCLES = 2000;                     // About 300 cycles of tests

   logic         clk;
   logic         rst_n;
   if2id_s       if2id;
   wrb2id_s      wrb2id;
   id2exe_ctrl_s ctrl;
   id2exe_data_s data;
   xlen_t        model [RF_DEPTH];                      // Expected register contents
   xlen_t        pc_cnt;
   integer       seed;
   int           cycle_cnt = 0;

   decode_stage u_dut (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .if2id_i       (if2id),
      .wrb2id_i      (wrb2id),
      .id2exe_ctrl_o (ctrl),
      .id2exe_data_o (data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= MAX_CYCLES);
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "timeout");
   end

   // RV32I encoders, immediates given as raw fields
   function automatic xlen_t encode_r(logic [6:0] f7, rf_addr_t rs2, rf_addr_t rs1,
                                      logic [2:0] f3, rf_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPCODE_ARITH, 2'b11};
   endfunction

   function automatic xlen_t encode_i(logic [11:0] imm, rf_addr_t rs1, logic [2:0] f3,
                                      rf_addr_t rd, rv_opcode_e opc);
      return {imm, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic xlen_t encode_s(logic [11:0] imm, rf_addr_t rs2, rf_addr_t rs1,
                                      logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE, 2'b11};
   endfunction

   function automatic xlen_t encode_b(logic [12:0] off, rf_addr_t rs2, rf_addr_t rs1,
                                      logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH, 2'b11};
   endfunction

   function automatic xlen_t encode_u(logic [19:0] imm, rf_addr_t rd, rv_opcode_e opc);
      return {imm, rd, opc, 2'b11};
   endfunction

   function automatic xlen_t encode_j(logic [20:0] off, rf_addr_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL, 2'b11};
   endfunction

   function automatic id2exe_ctrl_s expect_ctrl(alu_ops_e alu, ld_ops_e ld, st_ops_e st,
         br_ops_e br, rd_wrb_sel_e wrb, alu_opr1_sel_e opr1, alu_opr2_sel_e opr2,
         logic wr, logic jump);
      id2exe_ctrl_s c;
      c.alu_ops      = alu;
      c.ld_ops       = ld;
      c.st_ops       = st;
      c.branch_ops   = br;
      c.rd_wrb_sel   = wrb;
      c.alu_opr1_sel = opr1;
      c.alu_opr2_sel = opr2;
      c.rd_wr_req    = wr;
      c.jump_req     = jump;
      c.branch_req   = (br != BR_OPS_NONE);
      c.exc_req      = 1'b0;
      c.irq_req      = 1'b0;
      return c;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         $display("TEST FAIL");
         $fatal(1, "check failed");
      end
   endtask

   task automatic write_reg(input rf_addr_t addr, input xlen_t value);
      wrb2id.rd_wr_req = 1'b1;
      wrb2id.rd_addr   = addr;
      wrb2id.rd_data   = value;
      if (addr != '0) begin
         model[addr] = value;                            // x0 stays zero
      end
      @(posedge clk);
      #1;
      wrb2id.rd_wr_req = 1'b0;
   endtask

   // Present one fetch bundle, return once it sits in the ID/EXE register
   task automatic decode_full(input xlen_t instr, input logic exc, input exc_code_t code,
                              input logic irq, input logic flushed);
      if2id.pc            = pc_cnt;
      if2id.pc_next       = pc_cnt + 32'd4;
      if2id.instr         = instr;
      if2id.exc_req       = exc;
      if2id.exc_code      = code;
      if2id.irq_req       = irq;
      if2id.instr_flushed = flushed;
      pc_cnt              = pc_cnt + 32'd4;
      @(posedge clk);
      #1;
   endtask

   task automatic decode(input xlen_t instr);
      decode_full(instr, 1'b0, 4'd0, 1'b0, 1'b0);
   endtask

   task automatic check_ctrl(input string name, input id2exe_ctrl_s exp);
      check({name, " ctrl"}, 32'(exp), 32'(ctrl));
      check({name, " exc_code"}, 32'(EXC_CODE_NO_EXCEPTION), 32'(data.exc_code));
   endtask

   task automatic check_squashed(input string name, input exc_code_t code);
      check({name, " ops"}, 32'd0, 32'({ctrl.alu_ops, ctrl.ld_ops, ctrl.st_ops,
            ctrl.branch_ops, ctrl.rd_wrb_sel}));
      check({name, " wr/jump/branch/exc"}, 32'b0001,
            32'({ctrl.rd_wr_req, ctrl.jump_req, ctrl.branch_req, ctrl.exc_req}));
      check({name, " exc_code"}, 32'(code), 32'(data.exc_code));
   endtask

   task automatic check_passthrough(input string name);
      check({name, " irq"}, 32'(if2id.irq_req), 32'(ctrl.irq_req));
      check({name, " pc"}, if2id.pc, data.pc);
      check({name, " pc_next"}, if2id.pc_next, data.pc_next);
      check({name, " instr"}, if2id.instr, data.instr);
      check({name, " flushed"}, 32'(if2id.instr_flushed), 32'(data.instr_flushed));
   endtask

   task automatic test_reset();
      check("reset ctrl", 32'(expect_ctrl(ALU_OPS_NONE, LD_OPS_NONE, ST_OPS_NONE,
            BR_OPS_NONE, RD_WRB_NONE, ALU_OPR1_PC, ALU_OPR2_REG, 1'b0, 1'b0)), 32'(ctrl));
      check("reset exc_code", 32'(EXC_CODE_NO_EXCEPTION), 32'(data.exc_code));
      check("reset imm", 32'd0, data.imm);
      check("reset pc", 32'd0, data.pc);
      check("reset pc_next", 32'd0, data.pc_next);
      check("reset instr", 32'd0, data.instr);
      check("reset flushed", 32'd0, 32'(data.instr_flushed));
   endtask

   task automatic run_r(input string name, input logic [6:0] f7, input logic [2:0] f3,
                        input alu_ops_e op);
      decode(encode_r(f7, 5'd2, 5'd1, f3, 5'd3));
      check_ctrl(name, expect_ctrl(op, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
                 ALU_OPR1_REG, ALU_OPR2_REG, 1'b1, 1'b0));
      check({name, " rs1"}, model[1], data.rs1_data);
      check({name, " rs2"}, model[2], data.rs2_data);
   endtask

   task automatic run_i(input string name, input logic [2:0] f3, input logic [11:0] imm,
                        input alu_ops_e op, input xlen_t exp_imm);
      decode(encode_i(imm, 5'd1, f3, 5'd4, OPCODE_IMM));
      check_ctrl(name, expect_ctrl(op, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
                 ALU_OPR1_REG, ALU_OPR2_IMM, 1'b1, 1'b0));
      check({name, " imm"}, exp_imm, data.imm);
      check({name, " rs1"}, model[1], data.rs1_data);
   endtask

   task automatic test_arith();
      write_reg(5'd1, 32'h1234_5678);
      write_reg(5'd2, 32'hFFFF_FF00);
      write_reg(5'd0, 32'hDEAD_BEEF);                    // Must be dropped
      run_r("add", 7'h00, 3'b000, ALU_OPS_ADD);
      run_r("sub", 7'h20, 3'b000, ALU_OPS_SUB);
      run_r("sll", 7'h00, 3'b001, ALU_OPS_SLL);
      run_r("slt", 7'h00, 3'b010, ALU_OPS_SLT);
      run_r("sltu", 7'h00, 3'b011, ALU_OPS_SLTU);
      run_r("xor", 7'h00, 3'b100, ALU_OPS_XOR);
      run_r("srl", 7'h00, 3'b101, ALU_OPS_SRL);
      run_r("sra", 7'h20, 3'b101, ALU_OPS_SRA);
      run_r("or", 7'h00, 3'b110, ALU_OPS_OR);
      run_r("and", 7'h00, 3'b111, ALU_OPS_AND);
      run_i("addi", 3'b000, 12'hFFB, ALU_OPS_ADD, 32'hFFFF_FFFB);
      run_i("slti", 3'b010, 12'h7FF, ALU_OPS_SLT, 32'h0000_07FF);
      run_i("sltiu", 3'b011, 12'h800, ALU_OPS_SLTU, 32'hFFFF_F800);
      run_i("xori", 3'b100, 12'hAAA, ALU_OPS_XOR, 32'hFFFF_FAAA);
      run_i("ori", 3'b110, 12'h555, ALU_OPS_OR, 32'h0000_0555);
      run_i("andi", 3'b111, 12'h0F0, ALU_OPS_AND, 32'h0000_00F0);
      run_i("slli", 3'b001, {7'h00, 5'd31}, ALU_OPS_SLL, 32'd31);
      run_i("srli", 3'b101, {7'h00, 5'd7}, ALU_OPS_SRL, 32'd7);
      run_i("srai", 3'b101, {7'h20, 5'd13}, ALU_OPS_SRA, 32'd13);   // funct7 not in imm
      decode(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));
      check("x0 rs1", 32'd0, data.rs1_data);
      check("x0 rs2", 32'd0, data.rs2_data);
   endtask

   task automatic run_load(input string name, input logic [2:0] f3, input ld_ops_e op);
      decode(encode_i(12'hFF0, 5'd2, f3, 5'd6, OPCODE_LOAD));
      check_ctrl(name, expect_ctrl(ALU_OPS_ADD, op, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_DMEM,
                 ALU_OPR1_REG, ALU_OPR2_IMM, 1'b1, 1'b0));
      check({name, " imm"}, 32'hFFFF_FFF0, data.imm);
   endtask

   task automatic run_store(input string name, input logic [2:0] f3, input st_ops_e op,
                            input logic [11:0] imm, input xlen_t exp_imm);
      decode(encode_s(imm, 5'd2, 5'd1, f3));
      check_ctrl(name, expect_ctrl(ALU_OPS_ADD, LD_OPS_NONE, op, BR_OPS_NONE, RD_WRB_NONE,
                 ALU_OPR1_REG, ALU_OPR2_IMM, 1'b0, 1'b0));
      check({name, " imm"}, exp_imm, data.imm);
      check({name, " rs2"}, model[2], data.rs2_data);
   endtask

   task automatic test_mem_upper();
      run_load("lb", 3'b000, LD_OPS_LB);
      run_load("lh", 3'b001, LD_OPS_LH);
      run_load("lw", 3'b010, LD_OPS_LW);
      run_load("lbu", 3'b100, LD_OPS_LBU);
      run_load("lhu", 3'b101, LD_OPS_LHU);
      run_store("sb", 3'b000, ST_OPS_SB, 12'h803, 32'hFFFF_F803);
      run_store("sh", 3'b001, ST_OPS_SH, 12'h7F5, 32'h0000_07F5);
      run_store("sw", 3'b010, ST_OPS_SW, 12'hFFC, 32'hFFFF_FFFC);
      decode(encode_u(20'hABCDE, 5'd7, OPCODE_LUI));
      check_ctrl("lui", expect_ctrl(ALU_OPS_COPY_OPR2, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
                 RD_WRB_ALU, ALU_OPR1_PC, ALU_OPR2_IMM, 1'b1, 1'b0));
      check("lui imm", 32'hABCD_E000, data.imm);
      decode(encode_u(20'h80001, 5'd8, OPCODE_AUIPC));
      check_ctrl("auipc", expect_ctrl(ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
                 RD_WRB_ALU, ALU_OPR1_PC, ALU_OPR2_IMM, 1'b1, 1'b0));
      check("auipc imm", 32'h8000_1000, data.imm);
   endtask

   task automatic run_branch(input string name, input logic [2:0] f3, input br_ops_e op,
                             input logic [12:0] off, input xlen_t exp_imm);
      decode(encode_b(off, 5'd2, 5'd1, f3));
      check_ctrl(name, expect_ctrl(ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, op, RD_WRB_NONE,
                 ALU_OPR1_PC, ALU_OPR2_IMM, 1'b0, 1'b0));
      check({name, " imm"}, exp_imm, data.imm);
   endtask

   task automatic test_control_flow();
      run_branch("beq", 3'b000, BR_OPS_EQ, 13'h1FF8, 32'hFFFF_FFF8);
      run_branch("bne", 3'b001, BR_OPS_NE, 13'h0FFE, 32'h0000_0FFE);
      run_branch("blt", 3'b100, BR_OPS_LT, 13'h1000, 32'hFFFF_F000);
      run_branch("bge", 3'b101, BR_OPS_GE, 13'h0010, 32'h0000_0010);
      run_branch("bltu", 3'b110, BR_OPS_LTU, 13'h1802, 32'hFFFF_F802);
      run_branch("bgeu", 3'b111, BR_OPS_GEU, 13'h0554, 32'h0000_0554);
      decode(encode_j(21'h18_1234, 5'd1));
      check_ctrl("jal", expect_ctrl(ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
                 RD_WRB_INC_PC, ALU_OPR1_PC, ALU_OPR2_IMM, 1'b1, 1'b0));
      check("jal imm", 32'hFFF8_1234, data.imm);
      decode(encode_i(12'h123, 5'd1, 3'b000, 5'd5, OPCODE_JALR));
      check_ctrl("jalr", expect_ctrl(ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
                 RD_WRB_INC_PC, ALU_OPR1_REG, ALU_OPR2_IMM, 1'b1, 1'b1));
      check("jalr imm", 32'h0000_0123, data.imm);
      check("jalr rs1", model[1], data.rs1_data);
   endtask

   task automatic test_exceptions();
      id2exe_ctrl_s exp;
      decode(encode_i(12'h000, 5'd1, 3'b011, 5'd3, OPCODE_LOAD));
      check_squashed("illegal load", EXC_CODE_ILLEGAL_INSTR);
      decode(encode_s(12'h000, 5'd2, 5'd1, 3'b011));
      check_squashed("illegal store", EXC_CODE_ILLEGAL_INSTR);
      decode(encode_b(13'h0000, 5'd2, 5'd1, 3'b010));
      check_squashed("illegal branch", EXC_CODE_ILLEGAL_INSTR);
      decode(encode_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));    // MUL
      check_squashed("illegal funct7", EXC_CODE_ILLEGAL_INSTR);
      decode(32'h0000_100F);                                // FENCE.I
      check_squashed("fence.i", EXC_CODE_ILLEGAL_INSTR);
      decode(32'h0000_0073);                                // ECALL
      check_squashed("ecall", EXC_CODE_ILLEGAL_INSTR);
      decode_full(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 4'd1, 1'b0, 1'b0);
      check_squashed("fetch exc legal", 4'd1);
      decode_full(32'h0000_0073, 1'b1, 4'd5, 1'b0, 1'b1);
      check_squashed("fetch exc over illegal", 4'd5);
      check_passthrough("fetch exc over illegal");
      exp         = expect_ctrl(ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
                                RD_WRB_ALU, ALU_OPR1_REG, ALU_OPR2_REG, 1'b1, 1'b0);
      exp.irq_req = 1'b1;
      decode_full(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, 4'd0, 1'b1, 1'b1);
      check_ctrl("irq on add", exp);
      check_passthrough("irq on add");
      decode_full(32'h0000_0073, 1'b0, 4'd0, 1'b1, 1'b0);
      check_squashed("irq on illegal", EXC_CODE_ILLEGAL_INSTR);
      check_passthrough("irq on illegal");
   endtask

   task automatic test_random_traffic();
      xlen_t    rnd;
      rf_addr_t ra;
      rf_addr_t rb;
      for (int i = 0; i < 48; i++) begin
         rnd = $random(seed);
         write_reg(rnd[4:0], $random(seed));
      end
      for (int i = 0; i < 96; i++) begin
         rnd = $random(seed);
         ra  = rnd[19:15];
         rb  = rnd[24:20];
         if (rnd[0]) begin
            write_reg(ra, $random(seed));                // Read right after the write
         end
         decode(encode_r(7'h00, rb, ra, 3'b000, rnd[11:7]));
         check($sformatf("random add %0d rs1 x%0d", i, ra), model[ra], data.rs1_data);
         check($sformatf("random add %0d rs2 x%0d", i, rb), model[rb], data.rs2_data);
      end
   endtask

   initial begin
      rst_n  = 1'b0;
      if2id  = '0;
      wrb2id = '0;
      pc_cnt = 32'h0000_1000;
      seed   = 32'h5736c66e;
      if2id.pc            = 32'h0000_0F00;               // Live fetch traffic during reset
      if2id.pc_next       = 32'h0000_0F04;
      if2id.instr         = encode_i(12'h7FF, 5'd1, 3'b000, 5'd1, OPCODE_IMM);
      if2id.irq_req       = 1'b1;
      if2id.instr_flushed = 1'b1;
      for (int i = 0; i < RF_DEPTH; i++) begin
         model[i] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      test_reset();
      rst_n = 1'b1;
      test_arith();
      test_mem_upper();
      test_control_flow();
      test_exceptions();
      test_random_traffic();
      $display("TEST PASS");
      $finish;
   end

endmodule : tb_decode_stage

/* vlog.f */
common/decode_pkg.sv
decoder/ctrl_decoder.sv
design/imm_gen.sv
regfile/reg_file.sv
design/decode_stage.sv
tb/tb_decode_stage.sv
